//--- verilog/audio_pkg.sv
`default_nettype none

package audio_pkg;

    typedef logic [23:0] addr_t;
    typedef logic signed [11:0] delta_t;
    typedef logic signed [15:0] sample_t;
    typedef logic [7:0] volume_t;
    typedef logic [23:0] reg_data_t;

    // A volume of 16 passes the sample through unchanged
    localparam int VOLUME_SHIFT = 4;

    typedef enum logic [2:0] {
        REG_START_ADDR   = 3'd0,
        REG_SAMPLE_COUNT = 3'd1,
        REG_LOOP_START   = 3'd2,
        REG_LOOP_END     = 3'd3,
        REG_POSITION     = 3'd4,
        REG_LAST_SAMPLE  = 3'd5,
        REG_VOLUME       = 3'd6,
        REG_FLAGS        = 3'd7
    } reg_sel_t;

    // Written as data bits 3..0 in this order, looping in bit 3
    typedef struct packed {
        logic looping;
        logic playing;
        logic mono;
        logic left;
    } channel_flags_t;

    typedef struct packed {
        addr_t          start_addr;
        addr_t          sample_count;
        addr_t          loop_start;
        addr_t          loop_end;
        volume_t        volume;
        channel_flags_t flags;
    } channel_cfg_t;

    typedef struct packed {
        logic    load_pos;
        addr_t   pos_value;
        logic    load_last;
        sample_t last_value;
    } channel_load_t;

    // Left goes out first, in the upper half
    typedef struct packed {
        sample_t left;
        sample_t right;
    } frame_t;

endpackage

`default_nettype wire

//--- verilog/channel_regs.sv
`timescale 1ns/100ps
`default_nettype none

module channel_regs (
    input  wire logic                   clk_25mhz,
    input  wire logic                   i_arst_n,
    input  wire logic                   i_reg_wr,
    input  wire audio_pkg::reg_sel_t    i_reg_sel,
    input  wire audio_pkg::reg_data_t   i_reg_data,
    output audio_pkg::channel_cfg_t     o_cfg,
    output audio_pkg::channel_load_t    o_load
);

    audio_pkg::channel_cfg_t cfg_q;
    logic                    load_pos_q;
    logic                    load_last_q;
    audio_pkg::addr_t        pos_value_q;
    audio_pkg::sample_t      last_value_q;

    always_ff @(posedge clk_25mhz or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cfg_q       <= '0;
            load_pos_q  <= 1'b0;
            load_last_q <= 1'b0;
        end else begin
            load_pos_q  <= i_reg_wr && (i_reg_sel == audio_pkg::REG_POSITION);
            load_last_q <= i_reg_wr && (i_reg_sel == audio_pkg::REG_LAST_SAMPLE);
            if (i_reg_wr) begin
                case (i_reg_sel)
                    audio_pkg::REG_START_ADDR:   cfg_q.start_addr   <= i_reg_data;
                    audio_pkg::REG_SAMPLE_COUNT: cfg_q.sample_count <= i_reg_data;
                    audio_pkg::REG_LOOP_START:   cfg_q.loop_start   <= i_reg_data;
                    audio_pkg::REG_LOOP_END:     cfg_q.loop_end     <= i_reg_data;
                    audio_pkg::REG_VOLUME:       cfg_q.volume       <= i_reg_data[7:0];
                    audio_pkg::REG_FLAGS: begin
                        cfg_q.flags <= audio_pkg::channel_flags_t'(i_reg_data[3:0]);
                    end
                    // Position and last sample live in the voice
                    default: ;
                endcase
            end
        end
    end

    // Values that ride along with the load pulses
    always_ff @(posedge clk_25mhz) begin
        if (i_reg_wr && (i_reg_sel == audio_pkg::REG_POSITION)) begin
            pos_value_q <= i_reg_data;
        end
        if (i_reg_wr && (i_reg_sel == audio_pkg::REG_LAST_SAMPLE)) begin
            last_value_q <= audio_pkg::sample_t'(i_reg_data[15:0]);
        end
    end

    assign o_cfg             = cfg_q;
    assign o_load.load_pos   = load_pos_q;
    assign o_load.pos_value  = pos_value_q;
    assign o_load.load_last  = load_last_q;
    assign o_load.last_value = last_value_q;

    // The voice applies at most one override per cycle
    a_single_load: assert property (
        @(posedge clk_25mhz) disable iff (!i_arst_n)
        !(o_load.load_pos && o_load.load_last)
    );

endmodule

`default_nettype wire

//--- verilog/channel_voice.sv
`timescale 1ns/100ps
`default_nettype none

module channel_voice (
    input  wire logic                     clk_25mhz,
    input  wire logic                     i_arst_n,
    input  wire audio_pkg::channel_cfg_t  i_cfg,
    input  wire audio_pkg::channel_load_t i_load,
    input  wire logic                     i_frame_start,
    output logic                          o_sample_rd,
    output audio_pkg::addr_t              o_sample_addr,
    input  wire audio_pkg::delta_t        i_sample_delta,
    output audio_pkg::frame_t             o_frame
);

    audio_pkg::addr_t   position;
    audio_pkg::addr_t   pos_inc;
    audio_pkg::addr_t   pos_next;
    audio_pkg::sample_t last_sample;
    audio_pkg::sample_t acc_sat;
    audio_pkg::sample_t scaled;
    audio_pkg::frame_t  frame_q;
    audio_pkg::frame_t  frame_next;
    logic               rd_q;
    logic               scale_q;
    logic signed [16:0] acc_sum;
    logic signed [24:0] product;
    logic signed [24:0] shifted;

    // Fetch goes out in the frame start cycle itself
    assign o_sample_rd   = i_frame_start && i_cfg.flags.playing;
    assign o_sample_addr = i_cfg.start_addr + position;

    // The memory answers one cycle after the read
    assign acc_sum = {last_sample[15], last_sample}
                   + {{5{i_sample_delta[11]}}, i_sample_delta};

    always_comb begin
        if (acc_sum > 17'sd32767) begin
            acc_sat = 16'sh7fff;
        end else if (acc_sum < -17'sd32768) begin
            acc_sat = 16'sh8000;
        end else begin
            acc_sat = acc_sum[15:0];
        end
    end

    always_comb begin
        pos_inc = position + 1'b1;
        if (i_cfg.flags.looping) begin
            pos_next = (position == i_cfg.loop_end) ? i_cfg.loop_start : pos_inc;
        end else begin
            // Sits on the final sample once the count is used up
            pos_next = (pos_inc >= i_cfg.sample_count) ? position : pos_inc;
        end
    end

    assign product = last_sample * $signed({1'b0, i_cfg.volume});
    assign shifted = product >>> audio_pkg::VOLUME_SHIFT;

    always_comb begin
        if (shifted > 25'sd32767) begin
            scaled = 16'sh7fff;
        end else if (shifted < -25'sd32768) begin
            scaled = 16'sh8000;
        end else begin
            scaled = shifted[15:0];
        end
    end

    always_comb begin
        if (i_cfg.flags.mono) begin
            frame_next.left  = scaled;
            frame_next.right = scaled;
        end else if (i_cfg.flags.left) begin
            frame_next.left  = scaled;
            frame_next.right = '0;
        end else begin
            frame_next.left  = '0;
            frame_next.right = scaled;
        end
    end

    always_ff @(posedge clk_25mhz or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rd_q        <= 1'b0;
            scale_q     <= 1'b0;
            position    <= '0;
            last_sample <= '0;
            frame_q     <= '0;
        end else begin
            rd_q    <= o_sample_rd;
            scale_q <= rd_q;
            // Host overrides win over the per-frame update
            if (i_load.load_pos) begin
                position <= i_load.pos_value;
            end else if (rd_q) begin
                position <= pos_next;
            end
            if (i_load.load_last) begin
                last_sample <= i_load.last_value;
            end else if (rd_q) begin
                last_sample <= acc_sat;
            end
            if (scale_q) begin
                frame_q <= frame_next;
            end
        end
    end

    assign o_frame = frame_q;

    // Reads come one per frame start, never while the previous fetch is in flight
    a_read_on_frame: assert property (
        @(posedge clk_25mhz) disable iff (!i_arst_n)
        o_sample_rd |-> i_frame_start && !rd_q && !scale_q
    );

endmodule

`default_nettype wire

//--- verilog/i2s_serializer.sv
`timescale 1ns/100ps
`default_nettype none

module i2s_serializer #(
    parameter int BCLK_HALF = 12
) (
    input  wire logic              clk_25mhz,
    input  wire logic              i_arst_n,
    input  wire audio_pkg::frame_t i_frame,
    output logic                   o_frame_start,
    output logic                   o_bclk,
    output logic                   o_lrclk,
    output logic                   o_din
);

    localparam int DIV_W = (BCLK_HALF > 1) ? $clog2(BCLK_HALF) : 1;

    typedef enum logic {
        LEFT_SLOT  = 1'b0,
        RIGHT_SLOT = 1'b1
    } slot_state_t;

    slot_state_t      state;
    logic [DIV_W-1:0] div_cnt;
    logic [4:0]       bit_cnt;
    logic [31:0]      shift_q;
    logic             bclk_q;
    logic             frame_start_q;
    logic             half_tick;
    logic             bclk_fall;

    assign half_tick = (div_cnt == DIV_W'(BCLK_HALF - 1));
    assign bclk_fall = half_tick && bclk_q;

    always_ff @(posedge clk_25mhz or negedge i_arst_n) begin
        if (!i_arst_n) begin
            div_cnt       <= '0;
            bclk_q        <= 1'b0;
            // Starts on the last bit so the first falling edge opens a frame
            bit_cnt       <= 5'd31;
            state         <= LEFT_SLOT;
            shift_q       <= '0;
            frame_start_q <= 1'b0;
        end else begin
            frame_start_q <= 1'b0;
            if (half_tick) begin
                div_cnt <= '0;
                bclk_q  <= ~bclk_q;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (bclk_fall) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 5'd31) begin
                    shift_q       <= i_frame;
                    state         <= LEFT_SLOT;
                    frame_start_q <= 1'b1;
                end else begin
                    shift_q <= {shift_q[30:0], 1'b0};
                    if (bit_cnt == 5'd15) begin
                        state <= RIGHT_SLOT;
                    end
                end
            end
        end
    end

    assign o_bclk        = bclk_q;
    assign o_lrclk       = (state == RIGHT_SLOT);
    assign o_din         = shift_q[31];
    assign o_frame_start = frame_start_q;

    a_lrclk_on_fall: assert property (
        @(posedge clk_25mhz) disable iff (!i_arst_n)
        $changed(o_lrclk) |-> $fell(o_bclk)
    );

endmodule

`default_nettype wire

//--- verilog/audio_channel_top.sv
`timescale 1ns/100ps
`default_nettype none

module audio_channel_top #(
    parameter int BCLK_HALF = 12
) (
    input  wire logic                 clk_25mhz,
    input  wire logic                 i_arst_n,
    input  wire logic                 i_reg_wr,
    input  wire audio_pkg::reg_sel_t  i_reg_sel,
    input  wire audio_pkg::reg_data_t i_reg_data,
    output logic                      o_sample_rd,
    output audio_pkg::addr_t          o_sample_addr,
    input  wire audio_pkg::delta_t    i_sample_delta,
    output logic                      o_bclk,
    output logic                      o_lrclk,
    output logic                      o_din
);

    audio_pkg::channel_cfg_t  cfg;
    audio_pkg::channel_load_t load;
    audio_pkg::frame_t        frame;
    logic                     frame_start;

    channel_regs i_channel_regs (
        .clk_25mhz  (clk_25mhz),
        .i_arst_n   (i_arst_n),
        .i_reg_wr   (i_reg_wr),
        .i_reg_sel  (i_reg_sel),
        .i_reg_data (i_reg_data),
        .o_cfg      (cfg),
        .o_load     (load)
    );

    channel_voice i_channel_voice (
        .clk_25mhz      (clk_25mhz),
        .i_arst_n       (i_arst_n),
        .i_cfg          (cfg),
        .i_load         (load),
        .i_frame_start  (frame_start),
        .o_sample_rd    (o_sample_rd),
        .o_sample_addr  (o_sample_addr),
        .i_sample_delta (i_sample_delta),
        .o_frame        (frame)
    );

    i2s_serializer #(
        .BCLK_HALF (BCLK_HALF)
    ) i_i2s_serializer (
        .clk_25mhz     (clk_25mhz),
        .i_arst_n      (i_arst_n),
        .i_frame       (frame),
        .o_frame_start (frame_start),
        .o_bclk        (o_bclk),
        .o_lrclk       (o_lrclk),
        .o_din         (o_din)
    );

endmodule

`default_nettype wire

//--- tb/tb_audio_channel.sv
`timescale 1ns/100ps
`default_nettype none

module tb_audio_channel;

    localparam int BCLK_HALF = 2;
    localparam int FRAME_NS = 32 * 2 * BCLK_HALF * 40;
    localparam int TEST_FRAMES = 64;

    logic                    clk_25mhz = 1'b0;
    logic                    i_arst_n;
    logic                    i_reg_wr;
    audio_pkg::reg_sel_t     i_reg_sel;
    audio_pkg::reg_data_t    i_reg_data;
    audio_pkg::delta_t       i_sample_delta;
    logic                    o_sample_rd;
    audio_pkg::addr_t        o_sample_addr;
    logic                    o_bclk;
    logic                    o_lrclk;
    logic                    o_din;

    audio_pkg::delta_t       mem [256];
    audio_pkg::channel_cfg_t shadow = '0;
    audio_pkg::addr_t        model_pos = '0;
    audio_pkg::sample_t      model_last = '0;
    audio_pkg::frame_t       model_frame = '0;
    audio_pkg::frame_t       exp_frame = '0;
    logic [31:0]             rx_shift = '0;
    logic [31:0]             rng_state = 32'd73922;
    logic [7:0]              rd_index = '0;
    logic                    rd_pending = 1'b0;
    logic                    exp_valid = 1'b0;
    logic                    synced = 1'b0;
    logic                    bclk_prev = 1'b0;
    logic                    lr_prev = 1'b0;
    int                      rx_count = 0;
    int                      read_count = 0;
    int                      exp_reads = 0;
    int                      paused_reads = 0;
    int                      mismatches = 0;
    int                      failures = 0;
    string                   test_name = "reset";

    audio_channel_top #(
        .BCLK_HALF (BCLK_HALF)
    ) i_audio_channel_top (
        .clk_25mhz      (clk_25mhz),
        .i_arst_n       (i_arst_n),
        .i_reg_wr       (i_reg_wr),
        .i_reg_sel      (i_reg_sel),
        .i_reg_data     (i_reg_data),
        .o_sample_rd    (o_sample_rd),
        .o_sample_addr  (o_sample_addr),
        .i_sample_delta (i_sample_delta),
        .o_bclk         (o_bclk),
        .o_lrclk        (o_lrclk),
        .o_din          (o_din)
    );

    always #20 clk_25mhz = ~clk_25mhz;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic audio_pkg::sample_t clamp_sample(input int v);
        if (v > 32767) return 16'sh7fff;
        if (v < -32768) return 16'sh8000;
        return audio_pkg::sample_t'(v);
    endfunction

    task automatic check_addr(input string what, input audio_pkg::addr_t exp,
                              input audio_pkg::addr_t act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s read address: expected %06h, actual %06h", what, exp, act);
        end
    endtask

    task automatic check_frame(input string what, input audio_pkg::frame_t exp,
                               input audio_pkg::frame_t act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s frame: expected %08h, actual %08h", what, exp, act);
        end
    endtask

    // Reference model of one fetch, accumulate and scale step
    task automatic apply_read(input audio_pkg::delta_t delta);
        audio_pkg::sample_t scaled;
        model_last = clamp_sample(int'(model_last) + int'(delta));
        if (shadow.flags.looping) begin
            model_pos = (model_pos == shadow.loop_end) ? shadow.loop_start : model_pos + 24'd1;
        end else if (model_pos < shadow.sample_count - 24'd1) begin
            model_pos = model_pos + 24'd1;
        end
        scaled = clamp_sample((int'(model_last) * int'(shadow.volume)) >>> audio_pkg::VOLUME_SHIFT);
        model_frame.left  = (shadow.flags.mono || shadow.flags.left) ? scaled : 16'sd0;
        model_frame.right = (shadow.flags.mono || !shadow.flags.left) ? scaled : 16'sd0;
    endtask

    task automatic write_reg(input audio_pkg::reg_sel_t sel, input audio_pkg::reg_data_t data);
        @(posedge clk_25mhz);
        #1;
        i_reg_wr   = 1'b1;
        i_reg_sel  = sel;
        i_reg_data = data;
        case (sel)
            audio_pkg::REG_START_ADDR:   shadow.start_addr = data;
            audio_pkg::REG_SAMPLE_COUNT: shadow.sample_count = data;
            audio_pkg::REG_LOOP_START:   shadow.loop_start = data;
            audio_pkg::REG_LOOP_END:     shadow.loop_end = data;
            audio_pkg::REG_POSITION:     model_pos = data;
            audio_pkg::REG_LAST_SAMPLE:  model_last = data[15:0];
            audio_pkg::REG_VOLUME:       shadow.volume = data[7:0];
            default:                     shadow.flags = audio_pkg::channel_flags_t'(data[3:0]);
        endcase
        @(posedge clk_25mhz);
        #1;
        i_reg_wr = 1'b0;
    endtask

    // Returns in the middle of a frame, far from the reads at frame start
    task automatic wait_frames(input int n);
        repeat (n) @(posedge o_lrclk);
    endtask

    always @(negedge clk_25mhz) begin
        rd_pending = o_sample_rd;
        if (o_sample_rd) begin
            read_count++;
            rd_index = o_sample_addr[7:0];
            check_addr(test_name, shadow.start_addr + model_pos, o_sample_addr);
            if (o_sample_addr > 24'd255) begin
                failures++;
                $display("read address %06h lies outside the sample memory", o_sample_addr);
            end
            apply_read(mem[rd_index]);
        end
    end

    // Sample memory with one cycle of read latency
    initial begin
        i_sample_delta = '0;
        forever begin
            @(posedge clk_25mhz);
            #1;
            i_sample_delta = rd_pending ? mem[rd_index] : 12'sd0;
        end
    end

    // A frame shows the model state from the end of the frame before it
    always @(negedge clk_25mhz) begin
        if (o_bclk && !bclk_prev) begin
            if (!o_lrclk && lr_prev) begin
                if (synced && rx_count != 32) begin
                    failures++;
                    $display("an lrclk frame spanned %0d bclk periods instead of 32", rx_count);
                end
                // Every frame that opens while playing owes one sample read
                if (shadow.flags.playing) begin
                    exp_reads++;
                end
                synced = 1'b1;
                rx_count = 0;
            end
            if (synced) begin
                if (o_lrclk != (rx_count >= 16)) begin
                    failures++;
                    $display("lrclk is out of step with bit %0d of the frame", rx_count);
                end
                rx_shift = {rx_shift[30:0], o_din};
                rx_count++;
                if (rx_count == 32) begin
                    if (exp_valid) check_frame(test_name, exp_frame, audio_pkg::frame_t'(rx_shift));
                    exp_frame = model_frame;
                    exp_valid = 1'b1;
                end
            end
            lr_prev = o_lrclk;
        end
        bclk_prev = o_bclk;
    end

    initial begin
        #(TEST_FRAMES * FRAME_NS + 16 * FRAME_NS);
        $display("timeout: the run did not finish within %0d frames", TEST_FRAMES + 16);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        i_arst_n   = 1'b0;
        i_reg_wr   = 1'b0;
        i_reg_sel  = audio_pkg::REG_START_ADDR;
        i_reg_data = '0;
        // Low quarter climbs hard and the next quarter falls hard
        for (int i = 0; i < 256; i++) begin
            rng_state = xorshift32(rng_state);
            if (i < 64) mem[i] = {2'b01, rng_state[9:0]};
            else if (i < 128) mem[i] = {2'b10, rng_state[9:0]};
            else mem[i] = rng_state[11:0];
        end
        repeat (16) @(posedge clk_25mhz);
        @(negedge clk_25mhz);
        if (o_bclk || o_lrclk || o_din || o_sample_rd) begin
            failures++;
            $display("bclk, lrclk, din or the read strobe is not low in reset");
        end
        @(posedge clk_25mhz);
        #1;
        i_arst_n = 1'b1;

        test_name = "mono";
        wait_frames(2);
        write_reg(audio_pkg::REG_START_ADDR, 24'd0);
        write_reg(audio_pkg::REG_SAMPLE_COUNT, 24'd60);
        write_reg(audio_pkg::REG_POSITION, 24'd0);
        write_reg(audio_pkg::REG_LAST_SAMPLE, 24'd30000);
        write_reg(audio_pkg::REG_VOLUME, 24'd16);
        write_reg(audio_pkg::REG_FLAGS, 24'h6);
        for (int f = 0; f < 16; f++) begin
            wait_frames(1);
            if (f == 8) begin
                write_reg(audio_pkg::REG_START_ADDR, 24'd64);
                write_reg(audio_pkg::REG_LAST_SAMPLE, 24'h008ad0);
            end
            rng_state = xorshift32(rng_state);
            write_reg(audio_pkg::REG_VOLUME, {16'd0, rng_state[7:0]});
        end

        test_name = "looping";
        wait_frames(1);
        write_reg(audio_pkg::REG_START_ADDR, 24'd128);
        write_reg(audio_pkg::REG_LOOP_START, 24'd3);
        write_reg(audio_pkg::REG_LOOP_END, 24'd7);
        write_reg(audio_pkg::REG_POSITION, 24'd0);
        write_reg(audio_pkg::REG_VOLUME, 24'd16);
        write_reg(audio_pkg::REG_FLAGS, 24'he);
        wait_frames(14);

        test_name = "end of sample";
        write_reg(audio_pkg::REG_START_ADDR, 24'd140);
        write_reg(audio_pkg::REG_SAMPLE_COUNT, 24'd5);
        write_reg(audio_pkg::REG_POSITION, 24'd0);
        write_reg(audio_pkg::REG_FLAGS, 24'h5);
        wait_frames(9);
        rng_state = xorshift32(rng_state);
        write_reg(audio_pkg::REG_POSITION, 24'd1);
        write_reg(audio_pkg::REG_LAST_SAMPLE, {8'd0, rng_state[15:0]});
        wait_frames(4);

        test_name = "stereo right";
        write_reg(audio_pkg::REG_FLAGS, 24'h4);
        wait_frames(4);

        test_name = "pause";
        write_reg(audio_pkg::REG_FLAGS, 24'h0);
        paused_reads = read_count;
        wait_frames(6);
        if (read_count != paused_reads) begin
            failures++;
            $display("%0d sample reads were issued while paused", read_count - paused_reads);
        end
        wait_frames(2);

        if (read_count != exp_reads) begin
            failures++;
            $display("%0d sample reads were issued while %0d frames opened during playback",
                     read_count, exp_reads);
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
verilog/audio_pkg.sv
verilog/channel_regs.sv
verilog/channel_voice.sv
verilog/i2s_serializer.sv
verilog/audio_channel_top.sv
tb/tb_audio_channel.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_audio_channel \
    -f tb.f -o sim_audio_channel
./obj_dir/sim_audio_channel > sim.log 2>&1
cat sim.log
if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    exit 1
fi
exit 0
